// ==== hdl/axi_xlat_pkg.sv ====
/*
 * AXI translator package
 * Bus widths, field types, channel structs, AXI encodings and the
 * byte-level odd parity functions shared by the Lite to AXI4 translator.
 */
package axi_xlat_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int addr_width    = 32;
    localparam int data_width    = 32;
    localparam int strb_width    = data_width / 8;
    localparam int addrchk_width = (addr_width + 7) / 8;
    localparam int id_width      = 8;

    // Field types
    typedef logic [addr_width-1:0]    addr_t;
    typedef logic [data_width-1:0]    data_t;
    typedef logic [strb_width-1:0]    strb_t;
    typedef logic [addrchk_width-1:0] addrchk_t;
    typedef logic [strb_width-1:0]    datachk_t;
    typedef logic [id_width-1:0]      id_t;
    typedef logic [2:0]               prot_t;
    typedef logic [1:0]               resp_t;
    typedef logic [7:0]               len_t;
    typedef logic [2:0]               size_t;
    typedef logic [1:0]               burst_t;
    typedef logic [3:0]               cache_t;
    typedef logic [3:0]               qos_t;
    typedef logic [3:0]               region_t;

    // --------------------
    // AXI encodings
    // --------------------
    // Size of a full-width beat, log2 of the byte count
    localparam size_t  burst_size_default = size_t'($clog2(strb_width));
    localparam burst_t burst_incr         = 2'b01;
    localparam resp_t  resp_okay          = 2'b00;

    // --------------------
    // Channel structs
    // --------------------
    // Address channel as the Lite manager presents it
    typedef struct packed {
        addr_t    addr;
        prot_t    prot;
        addrchk_t addrchk;
    } lite_addr_t;

    // Complete AXI4 address channel
    typedef struct packed {
        id_t      id;
        addr_t    addr;
        len_t     len;
        size_t    size;
        burst_t   burst;
        logic     lock;
        cache_t   cache;
        prot_t    prot;
        qos_t     qos;
        region_t  region;
        addrchk_t addrchk;
    } full_addr_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } lite_wdata_t;

    typedef struct packed {
        data_t    data;
        strb_t    strb;
        logic     last;
        datachk_t datachk;
    } full_wdata_t;

    // Read data beat, same layout on both sides
    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  last;
    } rdata_t;

    // --------------------
    // Parity functions
    // --------------------
    // One odd parity bit per data byte
    function automatic datachk_t byte_parity(input data_t data);
        datachk_t chk;
        for (int i = 0; i < strb_width; i++) begin
            chk[i] = ~(^data[i*8 +: 8]);
        end
        return chk;
    endfunction

    // Same per-byte odd parity over the address, top byte zero padded
    function automatic addrchk_t addr_parity(input addr_t addr);
        logic [addrchk_width*8-1:0] padded;
        addrchk_t                   chk;
        padded                 = '0;
        padded[addr_width-1:0] = addr;
        for (int i = 0; i < addrchk_width; i++) begin
            chk[i] = ~(^padded[i*8 +: 8]);
        end
        return chk;
    endfunction

endpackage

// ==== hdl/axi_addr_adapter.sv ====
/*
 * Address channel adapter
 * Expands a Lite address beat into a complete AXI4 address beat and
 * regenerates the address parity, carrying any entry error onward.
 */
module axi_addr_adapter (
    input  logic                     aclk,
    input  logic                     reset,
    input  axi_xlat_pkg::lite_addr_t lite,
    input  logic                     valid,
    output axi_xlat_pkg::full_addr_t full,
    output logic                     parity_err
);

    // Parity the address should carry if it arrived intact
    axi_xlat_pkg::addrchk_t expected_chk;

    // --------------------
    // Parity check
    // --------------------
    assign expected_chk = axi_xlat_pkg::addr_parity(lite.addr);
    assign parity_err   = (lite.addrchk != expected_chk);

    // --------------------
    // Field expansion
    // --------------------
    always_comb begin
        // Lite carries no ID, a single beat per transfer
        full.id     = '0;
        full.len    = '0;
        full.size   = axi_xlat_pkg::burst_size_default;
        full.burst  = axi_xlat_pkg::burst_incr;

        // Normal access, non-bufferable, no QoS or region
        full.lock   = 1'b0;
        full.cache  = '0;
        full.qos    = '0;
        full.region = '0;

        full.addr   = lite.addr;
        full.prot   = lite.prot;

        // Poisoned parity on the way out so the error is not masked
        if (parity_err) begin
            full.addrchk = ~expected_chk;
        end else begin
            full.addrchk = expected_chk;
        end
    end

    // --------------------
    // Assertions
    // --------------------
    // The subordinate must never see a burst from this port
    len_single_beat: assert property (
        @(posedge aclk) disable iff (reset)
        valid |-> (full.len == '0)
    ) else $error("address beat issued with len %0h", full.len);

endmodule

// ==== hdl/axi_wdata_adapter.sv ====
/*
 * Write data adapter
 * Completes the write data channel with a forced WLAST and
 * generated per-byte odd data parity.
 */
module axi_wdata_adapter (
    input  logic                      aclk,
    input  logic                      reset,
    input  axi_xlat_pkg::lite_wdata_t lite,
    input  logic                      valid,
    output axi_xlat_pkg::full_wdata_t full
);

    // --------------------
    // Data path
    // --------------------
    always_comb begin
        full.data    = lite.data;
        full.strb    = lite.strb;

        // Every Lite write is one beat, so it is always the last
        full.last    = 1'b1;

        // Manager has no data check bits, build them here
        full.datachk = axi_xlat_pkg::byte_parity(lite.data);
    end

    // --------------------
    // Assertions
    // --------------------
    wlast_on_valid: assert property (
        @(posedge aclk) disable iff (reset)
        valid |-> full.last
    ) else $error("write beat issued without wlast");

endmodule

// ==== hdl/axi_resp_adapter.sv ====
/*
 * Response adapter
 * Returns write responses and read data to the Lite manager,
 * closing each read beat and generating read data parity.
 */
module axi_resp_adapter (
    input  logic                   aclk,
    input  logic                   reset,
    input  axi_xlat_pkg::rdata_t   m0_rdata,
    input  logic                   m0_rvalid,
    input  axi_xlat_pkg::resp_t    m0_bresp,
    output axi_xlat_pkg::rdata_t   s0_rdata,
    output axi_xlat_pkg::datachk_t s0_rdatachk,
    output axi_xlat_pkg::resp_t    s0_bresp
);

    // --------------------
    // Write response
    // --------------------
    // Response code goes back unchanged, the m0 ID is dropped
    assign s0_bresp = m0_bresp;

    // --------------------
    // Read data
    // --------------------
    always_comb begin
        s0_rdata.data = m0_rdata.data;
        s0_rdata.resp = m0_rdata.resp;

        // Lite reads are single beats
        s0_rdata.last = 1'b1;
    end

    // Subordinate supplies no data parity, so generate it from the beat
    assign s0_rdatachk = axi_xlat_pkg::byte_parity(m0_rdata.data);

    // --------------------
    // Assertions
    // --------------------
    // Only len zero reads go out on m0, so any returning beat must be
    // the last one of its burst
    m0_rlast_single: assert property (
        @(posedge aclk) disable iff (reset)
        m0_rvalid |-> m0_rdata.last
    ) else $error("m0 read beat returned without rlast");

endmodule

// ==== hdl/axi_lite_translator.sv ====
/*
 * AXI4-Lite to AXI4 translator
 * Joins the address, write data and response adapters between a Lite
 * manager on s0 and a full AXI4 subordinate on m0. No pipeline stages.
 */
module axi_lite_translator (
    input  logic                      aclk,
    input  logic                      reset,

    // --------------------
    // Lite manager side
    // --------------------
    input  axi_xlat_pkg::lite_addr_t  s0_aw,
    input  logic                      s0_awvalid,
    output logic                      s0_awready,

    input  axi_xlat_pkg::lite_addr_t  s0_ar,
    input  logic                      s0_arvalid,
    output logic                      s0_arready,

    input  axi_xlat_pkg::lite_wdata_t s0_w,
    input  logic                      s0_wvalid,
    output logic                      s0_wready,

    output axi_xlat_pkg::resp_t       s0_bresp,
    output logic                      s0_bvalid,
    input  logic                      s0_bready,

    output axi_xlat_pkg::rdata_t      s0_rdata,
    output axi_xlat_pkg::datachk_t    s0_rdatachk,
    output logic                      s0_rvalid,
    input  logic                      s0_rready,

    // --------------------
    // AXI4 subordinate side
    // --------------------
    output axi_xlat_pkg::full_addr_t  m0_aw,
    output logic                      m0_awvalid,
    input  logic                      m0_awready,

    output axi_xlat_pkg::full_addr_t  m0_ar,
    output logic                      m0_arvalid,
    input  logic                      m0_arready,

    output axi_xlat_pkg::full_wdata_t m0_w,
    output logic                      m0_wvalid,
    input  logic                      m0_wready,

    input  axi_xlat_pkg::resp_t       m0_bresp,
    input  logic                      m0_bvalid,
    output logic                      m0_bready,

    input  axi_xlat_pkg::rdata_t      m0_rdata,
    input  logic                      m0_rvalid,
    output logic                      m0_rready,

    // Address parity errors seen on entry
    output logic                      aw_parity_err,
    output logic                      ar_parity_err
);

    // Handshakes pass straight across, valid forward and ready back
    assign m0_awvalid = s0_awvalid;
    assign s0_awready = m0_awready;
    assign m0_arvalid = s0_arvalid;
    assign s0_arready = m0_arready;
    assign m0_wvalid  = s0_wvalid;
    assign s0_wready  = m0_wready;
    assign s0_bvalid  = m0_bvalid;
    assign m0_bready  = s0_bready;
    assign s0_rvalid  = m0_rvalid;
    assign m0_rready  = s0_rready;

    // --------------------
    // Address channels
    // --------------------
    axi_addr_adapter aw_adapter (
        .aclk       (aclk),
        .reset      (reset),
        .lite       (s0_aw),
        .valid      (s0_awvalid),
        .full       (m0_aw),
        .parity_err (aw_parity_err)
    );

    axi_addr_adapter ar_adapter (
        .aclk       (aclk),
        .reset      (reset),
        .lite       (s0_ar),
        .valid      (s0_arvalid),
        .full       (m0_ar),
        .parity_err (ar_parity_err)
    );

    // --------------------
    // Write data
    // --------------------
    axi_wdata_adapter wdata_adapter (
        .aclk  (aclk),
        .reset (reset),
        .lite  (s0_w),
        .valid (s0_wvalid),
        .full  (m0_w)
    );

    // --------------------
    // Responses
    // --------------------
    axi_resp_adapter resp_adapter (
        .aclk        (aclk),
        .reset       (reset),
        .m0_rdata    (m0_rdata),
        .m0_rvalid   (m0_rvalid),
        .m0_bresp    (m0_bresp),
        .s0_rdata    (s0_rdata),
        .s0_rdatachk (s0_rdatachk),
        .s0_bresp    (s0_bresp)
    );

endmodule

// ==== tests/axi_lite_translator_checks.svh ====
/*
 * Translator checks
 * Concurrent assertions on every channel, with error counters per group.
 */

typedef enum logic [1:0] {
    addr_group,
    wdata_group,
    resp_group,
    handshake_group
} error_group_t;

int error_counts[4];

// --------------------
// Reference rules
// --------------------
// One check bit per byte, set so that the byte plus its bit hold an odd count of ones
function automatic logic [3:0] odd_parity(input logic [31:0] value);
    logic [3:0] chk;
    for (int i = 0; i < 4; i++) begin
        chk[i] = ~(^value[i*8 +: 8]);
    end
    return chk;
endfunction

function automatic logic parity_bad(input axi_xlat_pkg::lite_addr_t lite);
    return lite.addrchk != odd_parity(lite.addr);
endfunction

function automatic axi_xlat_pkg::full_addr_t expected_addr(input axi_xlat_pkg::lite_addr_t lite);
    axi_xlat_pkg::full_addr_t beat;
    // Id, len, lock, cache, qos and region stay zero
    beat         = '0;
    beat.addr    = lite.addr;
    beat.prot    = lite.prot;
    beat.size    = 3'd2;
    beat.burst   = 2'b01;
    beat.addrchk = parity_bad(lite) ? ~odd_parity(lite.addr) : odd_parity(lite.addr);
    return beat;
endfunction

function automatic axi_xlat_pkg::full_wdata_t expected_wdata(
    input axi_xlat_pkg::lite_wdata_t lite
);
    axi_xlat_pkg::full_wdata_t beat;
    beat.data    = lite.data;
    beat.strb    = lite.strb;
    beat.last    = 1'b1;
    beat.datachk = odd_parity(lite.data);
    return beat;
endfunction

function automatic axi_xlat_pkg::rdata_t expected_rdata(input axi_xlat_pkg::rdata_t m0);
    axi_xlat_pkg::rdata_t beat;
    beat.data = m0.data;
    beat.resp = m0.resp;
    beat.last = 1'b1;
    return beat;
endfunction

task automatic count_mismatch(input error_group_t group, input string name,
                              input logic [127:0] expected, input logic [127:0] actual);
    error_counts[group]++;
    $display("** Error %s: expected %0h, actual %0h at time %0t",
             name, expected, actual, $time);
endtask

// --------------------
// Assertions
// --------------------
aw_payload: assert property (@(posedge aclk) disable iff (reset)
    m0_aw == expected_addr(s0_aw))
    else count_mismatch(addr_group, "m0_aw",
                        128'(expected_addr($sampled(s0_aw))), 128'($sampled(m0_aw)));

ar_payload: assert property (@(posedge aclk) disable iff (reset)
    m0_ar == expected_addr(s0_ar))
    else count_mismatch(addr_group, "m0_ar",
                        128'(expected_addr($sampled(s0_ar))), 128'($sampled(m0_ar)));

parity_err_flags: assert property (@(posedge aclk) disable iff (reset)
    {aw_parity_err, ar_parity_err} == {parity_bad(s0_aw), parity_bad(s0_ar)})
    else count_mismatch(addr_group, "{aw_parity_err, ar_parity_err}",
                        128'({parity_bad($sampled(s0_aw)), parity_bad($sampled(s0_ar))}),
                        128'($sampled({aw_parity_err, ar_parity_err})));

w_payload: assert property (@(posedge aclk) disable iff (reset)
    m0_w == expected_wdata(s0_w))
    else count_mismatch(wdata_group, "m0_w",
                        128'(expected_wdata($sampled(s0_w))), 128'($sampled(m0_w)));

r_payload: assert property (@(posedge aclk) disable iff (reset)
    s0_rdata == expected_rdata(m0_rdata))
    else count_mismatch(resp_group, "s0_rdata",
                        128'(expected_rdata($sampled(m0_rdata))), 128'($sampled(s0_rdata)));

r_parity: assert property (@(posedge aclk) disable iff (reset)
    s0_rdatachk == odd_parity(m0_rdata.data))
    else count_mismatch(resp_group, "s0_rdatachk",
                        128'(odd_parity($sampled(m0_rdata.data))), 128'($sampled(s0_rdatachk)));

b_resp: assert property (@(posedge aclk) disable iff (reset)
    s0_bresp == m0_bresp)
    else count_mismatch(resp_group, "s0_bresp",
                        128'($sampled(m0_bresp)), 128'($sampled(s0_bresp)));

// Bit order aw, ar, w, b, r
valid_forward: assert property (@(posedge aclk) disable iff (reset)
    {m0_awvalid, m0_arvalid, m0_wvalid, s0_bvalid, s0_rvalid}
        == {s0_awvalid, s0_arvalid, s0_wvalid, m0_bvalid, m0_rvalid})
    else count_mismatch(handshake_group, "valids",
        128'($sampled({s0_awvalid, s0_arvalid, s0_wvalid, m0_bvalid, m0_rvalid})),
        128'($sampled({m0_awvalid, m0_arvalid, m0_wvalid, s0_bvalid, s0_rvalid})));

ready_return: assert property (@(posedge aclk) disable iff (reset)
    {s0_awready, s0_arready, s0_wready, m0_bready, m0_rready}
        == {m0_awready, m0_arready, m0_wready, s0_bready, s0_rready})
    else count_mismatch(handshake_group, "readies",
        128'($sampled({m0_awready, m0_arready, m0_wready, s0_bready, s0_rready})),
        128'($sampled({s0_awready, s0_arready, s0_wready, m0_bready, m0_rready})));

// ==== tests/axi_lite_translator_tb.sv ====
/*
 * Testbench for the AXI4-Lite to AXI4 translator
 * Random traffic on every channel, checked by concurrent assertions.
 */
module axi_lite_translator_tb;

    localparam int clk_period    = 100;
    localparam int run_cycles    = 1000;
    // Twice the run length plus some slack
    localparam int watchdog_time = 2 * run_cycles * clk_period + 20 * clk_period;

    logic aclk = 1'b0;
    logic reset;

    axi_xlat_pkg::lite_addr_t  s0_aw;
    axi_xlat_pkg::lite_addr_t  s0_ar;
    axi_xlat_pkg::lite_wdata_t s0_w;
    axi_xlat_pkg::resp_t       s0_bresp;
    axi_xlat_pkg::rdata_t      s0_rdata;
    axi_xlat_pkg::datachk_t    s0_rdatachk;
    axi_xlat_pkg::full_addr_t  m0_aw;
    axi_xlat_pkg::full_addr_t  m0_ar;
    axi_xlat_pkg::full_wdata_t m0_w;
    axi_xlat_pkg::resp_t       m0_bresp;
    axi_xlat_pkg::rdata_t      m0_rdata;

    logic s0_awvalid, s0_awready, m0_awvalid, m0_awready;
    logic s0_arvalid, s0_arready, m0_arvalid, m0_arready;
    logic s0_wvalid, s0_wready, m0_wvalid, m0_wready;
    logic s0_bvalid, s0_bready, m0_bvalid, m0_bready;
    logic s0_rvalid, s0_rready, m0_rvalid, m0_rready;
    logic aw_parity_err;
    logic ar_parity_err;

    int addr_beats;
    int total_errors;

    axi_lite_translator axi_lite_translator_inst (.*);

    `include "axi_lite_translator_checks.svh"

    always #(clk_period / 2) aclk = ~aclk;

    // --------------------
    // Stimulus
    // --------------------
    task automatic make_addr_beat(input int beat, output axi_xlat_pkg::lite_addr_t addr_beat);
        addr_beat.addr    = $urandom;
        addr_beat.prot    = 3'($urandom);
        addr_beat.addrchk = odd_parity(addr_beat.addr);
        // Every fourth beat arrives with at least one check bit flipped
        if (beat % 4 == 3) begin
            addr_beat.addrchk = addr_beat.addrchk ^ (4'($urandom) | 4'b0001);
        end
    endtask

    task automatic drive_cycle();
        axi_xlat_pkg::lite_addr_t  aw_beat;
        axi_xlat_pkg::lite_addr_t  ar_beat;
        axi_xlat_pkg::lite_wdata_t w_beat;
        axi_xlat_pkg::rdata_t      r_beat;
        logic                      r_valid;

        // Read channel is offset so its bad beats never line up with write ones
        make_addr_beat(addr_beats, aw_beat);
        make_addr_beat(addr_beats + 2, ar_beat);
        addr_beats++;
        w_beat.data = $urandom;
        w_beat.strb = 4'($urandom);
        r_valid     = 1'($urandom);
        r_beat.data = $urandom;
        r_beat.resp = 2'($urandom);
        // Subordinate only answers single-beat reads, rlast is free while idle
        r_beat.last = r_valid ? 1'b1 : 1'($urandom);

        s0_aw      <= aw_beat;
        s0_ar      <= ar_beat;
        s0_w       <= w_beat;
        m0_rdata   <= r_beat;
        m0_bresp   <= 2'($urandom);
        s0_awvalid <= 1'($urandom);
        s0_arvalid <= 1'($urandom);
        s0_wvalid  <= 1'($urandom);
        m0_bvalid  <= 1'($urandom);
        m0_rvalid  <= r_valid;
        m0_awready <= 1'($urandom);
        m0_arready <= 1'($urandom);
        m0_wready  <= 1'($urandom);
        s0_bready  <= 1'($urandom);
        s0_rready  <= 1'($urandom);
    endtask

    task automatic init_inputs();
        s0_aw      <= '0;
        s0_ar      <= '0;
        s0_w       <= '0;
        m0_bresp   <= '0;
        m0_rdata   <= axi_xlat_pkg::rdata_t'(1);
        s0_awvalid <= 1'b0;
        s0_arvalid <= 1'b0;
        s0_wvalid  <= 1'b0;
        m0_bvalid  <= 1'b0;
        m0_rvalid  <= 1'b0;
        m0_awready <= 1'b0;
        m0_arready <= 1'b0;
        m0_wready  <= 1'b0;
        s0_bready  <= 1'b0;
        s0_rready  <= 1'b0;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        void'($urandom(32'h77b1_68ef));
        reset <= 1'b1;
        init_inputs();
        repeat (2) @(posedge aclk);
        reset <= 1'b0;

        repeat (run_cycles) begin
            @(posedge aclk);
            drive_cycle();
        end
        // Let the last beat be sampled and its checks report
        repeat (2) @(posedge aclk);

        total_errors = error_counts[0] + error_counts[1] + error_counts[2] + error_counts[3];
        $display("Error counts: address %0d, write data %0d, response %0d, handshake %0d",
                 error_counts[addr_group], error_counts[wdata_group],
                 error_counts[resp_group], error_counts[handshake_group]);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("Watchdog expired at %0t, the run did not finish in time", $time);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+tests
hdl/axi_xlat_pkg.sv
hdl/axi_addr_adapter.sv
hdl/axi_wdata_adapter.sv
hdl/axi_resp_adapter.sv
hdl/axi_lite_translator.sv
tests/axi_lite_translator_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the translator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module axi_lite_translator_tb \
    -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vaxi_lite_translator_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
